/* include/mandel_config.svh */
`ifndef MANDEL_CONFIG_SVH
`define MANDEL_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Frame geometry
////////////////////////////////////////////////////////////////////////////

`define SCREEN_W      32
`define SCREEN_H      24
`define COORD_W       10

////////////////////////////////////////////////////////////////////////////
// Fixed point and complex plane
////////////////////////////////////////////////////////////////////////////

// Signed, 4 integer bits and 14 fraction bits
`define FIX_W         18
`define FIX_FRAC      14

// Pixel 0,0 sits at (-2.0, 1.125), raw fixed-point values
`define RE_MIN        (-32768)
`define IM_MAX        18432
// 0.09375 per pixel in both directions
`define RE_STEP       1536
`define IM_STEP       1536

// Escape test
`define ITER_MAX      31
`define ITER_W        10
`define ESCAPE_LIMIT  (4 << `FIX_FRAC)

////////////////////////////////////////////////////////////////////////////
// Video memory and write window
////////////////////////////////////////////////////////////////////////////

// One byte per pixel, 1024-byte row stride
`define VIDEO_BASE    32'h0800_0000
`define ROW_SHIFT     10

// Cycles the window stays open after a sync rises
`define VS_HOLD       40
`define HS_HOLD       6

`define FIFO_DEPTH    8
`define FIFO_AW       3

`endif

/* source/mandel_pkg.sv */
`include "mandel_config.svh"

package mandel_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Data types
   ////////////////////////////////////////////////////////////////////////////

   // Point c of the plane being iterated
   typedef struct packed {
      logic signed [`FIX_W-1:0] re;
      logic signed [`FIX_W-1:0] im;
   } plane_point_t;

   // One byte-wide write to video memory
   typedef struct packed {
      logic [31:0] addr;
      logic [7:0]  data;
   } video_write_t;

   ////////////////////////////////////////////////////////////////////////////
   // FSM states
   ////////////////////////////////////////////////////////////////////////////

   // Iterator: clear z, iterate, then hold the result for the FIFO
   typedef enum logic [1:0] {
      ITER_LOAD,
      ITER_RUN,
      ITER_PUSH
   } iterator_state_t;

   // Writer: wait for data and window, then wait for the bus acknowledge
   typedef enum logic {
      WR_IDLE,
      WR_WAIT_ACK
   } writer_state_t;

endpackage

/* source/mandel_iterator.sv */
`timescale 1ns/100ps
`include "mandel_config.svh"

module mandel_iterator (
   input  logic                CLOCK2_50,
   input  logic                reset,
   input  logic                full,
   output logic                push,
   output logic [`ITER_W-1:0]  count
);

   localparam int FW = `FIX_W;

   localparam logic [`COORD_W-1:0] X_LAST = `COORD_W'(`SCREEN_W - 1);
   localparam logic [`COORD_W-1:0] Y_LAST = `COORD_W'(`SCREEN_H - 1);
   localparam logic [`ITER_W-1:0]  LIMIT  = `ITER_W'(`ITER_MAX);
   localparam logic signed [FW:0]  ESCAPE = (FW + 1)'(`ESCAPE_LIMIT);

   localparam mandel_pkg::plane_point_t START_POINT = '{
      re: FW'(`RE_MIN),
      im: FW'(`IM_MAX)
   };

   // Full-width product, shifted back to the fixed-point scale
   function automatic logic signed [FW-1:0] fix_mul(
      input logic signed [FW-1:0] a,
      input logic signed [FW-1:0] b
   );
      logic signed [2*FW-1:0] p;
      p = a * b;
      return FW'(p >>> `FIX_FRAC);
   endfunction

   mandel_pkg::iterator_state_t state;
   mandel_pkg::plane_point_t    c;

   logic [`COORD_W-1:0] x;
   logic [`COORD_W-1:0] y;

   // z and its squares for the current iteration
   logic signed [FW-1:0] zr;
   logic signed [FW-1:0] zi;
   logic signed [FW-1:0] zr2;
   logic signed [FW-1:0] zi2;

   logic signed [FW-1:0] zri;
   logic signed [FW-1:0] zr_next;
   logic signed [FW-1:0] zi_next;
   logic signed [FW-1:0] zr2_next;
   logic signed [FW-1:0] zi2_next;
   logic signed [FW:0]   mag_next;
   logic                 escape;

   logic [`ITER_W-1:0] iter;
   logic [`ITER_W-1:0] iter_next;
   logic               run_done;

   ////////////////////////////////////////////////////////////////////////////
   // One z^2 + c step per cycle
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      zri      = fix_mul(zr, zi);
      zr_next  = zr2 - zi2 + c.re;
      zi_next  = (zri <<< 1) + c.im;
      zr2_next = fix_mul(zr_next, zr_next);
      zi2_next = fix_mul(zi_next, zi_next);
      // Sum one bit wider so 4.0 and above cannot wrap
      mag_next = {zr2_next[FW-1], zr2_next} + {zi2_next[FW-1], zi2_next};
      escape   = mag_next > ESCAPE;
   end

   assign iter_next = iter + 1'b1;
   assign run_done  = escape || (iter_next == LIMIT);
   assign push      = (state == mandel_pkg::ITER_PUSH);

   // Control and coordinate stepper
   always_ff @(posedge CLOCK2_50) begin
      if (reset) begin
         state <= mandel_pkg::ITER_LOAD;
         x     <= '0;
         y     <= '0;
         c     <= START_POINT;
      end else begin
         case (state)
            mandel_pkg::ITER_LOAD: begin
               state <= mandel_pkg::ITER_RUN;
            end
            mandel_pkg::ITER_RUN: begin
               if (run_done) begin
                  state <= mandel_pkg::ITER_PUSH;
               end
            end
            mandel_pkg::ITER_PUSH: begin
               // Count taken by the FIFO, move to the next pixel
               if (!full) begin
                  state <= mandel_pkg::ITER_LOAD;
                  if (x == X_LAST) begin
                     x    <= '0;
                     c.re <= FW'(`RE_MIN);
                     if (y == Y_LAST) begin
                        y    <= '0;
                        c.im <= FW'(`IM_MAX);
                     end else begin
                        y    <= y + 1'b1;
                        c.im <= c.im - FW'(`IM_STEP);
                     end
                  end else begin
                     x    <= x + 1'b1;
                     c.re <= c.re + FW'(`RE_STEP);
                  end
               end
            end
            default: begin
               state <= mandel_pkg::ITER_LOAD;
            end
         endcase
      end
   end

   // Datapath
   always_ff @(posedge CLOCK2_50) begin
      case (state)
         mandel_pkg::ITER_LOAD: begin
            zr   <= '0;
            zi   <= '0;
            zr2  <= '0;
            zi2  <= '0;
            iter <= '0;
         end
         mandel_pkg::ITER_RUN: begin
            zr   <= zr_next;
            zi   <= zi_next;
            zr2  <= zr2_next;
            zi2  <= zi2_next;
            iter <= iter_next;
            if (run_done) begin
               count <= iter_next;
            end
         end
         default: begin
         end
      endcase
   end

   // Result offered to the FIFO is always inside the limit
   a_count_in_range: assert property (
      @(posedge CLOCK2_50) disable iff (reset)
      push |-> (count <= LIMIT)
   );

endmodule

/* source/iteration_fifo.sv */
`timescale 1ns/100ps
`include "mandel_config.svh"

module iteration_fifo (
   input  logic                CLOCK2_50,
   input  logic                reset,
   input  logic                push,
   input  logic [`ITER_W-1:0]  push_count,
   input  logic                pop,
   output logic [`ITER_W-1:0]  head_count,
   output logic                empty,
   output logic                full
);

   localparam logic [`FIFO_AW-1:0] PTR_LAST = `FIFO_AW'(`FIFO_DEPTH - 1);
   localparam logic [`FIFO_AW:0]   FILL_MAX = (`FIFO_AW + 1)'(`FIFO_DEPTH);

   // Pointer advance with wrap at the last entry
   function automatic logic [`FIFO_AW-1:0] ptr_step(input logic [`FIFO_AW-1:0] p);
      if (p == PTR_LAST) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   logic [`ITER_W-1:0]  mem [`FIFO_DEPTH];
   logic [`FIFO_AW-1:0] wr_ptr;
   logic [`FIFO_AW-1:0] rd_ptr;
   logic [`FIFO_AW:0]   fill;

   logic wr_en;
   logic rd_en;

   assign wr_en = push && !full;
   assign rd_en = pop && !empty;

   assign empty = (fill == '0);
   assign full  = (fill == FILL_MAX);

   // Show-ahead read
   assign head_count = mem[rd_ptr];

   always_ff @(posedge CLOCK2_50) begin
      if (wr_en) begin
         mem[wr_ptr] <= push_count;
      end
   end

   always_ff @(posedge CLOCK2_50) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= ptr_step(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= ptr_step(rd_ptr);
         end
         case ({wr_en, rd_en})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Handshake checks
   ////////////////////////////////////////////////////////////////////////////

   // Writer only pops a count it can see
   a_no_pop_empty: assert property (
      @(posedge CLOCK2_50) disable iff (reset)
      pop |-> !empty
   );

   // A push refused while full stays offered with the same count
   a_no_push_full: assert property (
      @(posedge CLOCK2_50) disable iff (reset)
      (push && full) |=> (push && $stable(push_count) && (wr_ptr == $past(wr_ptr)))
   );

endmodule

/* source/pixel_writer.sv */
`timescale 1ns/100ps
`include "mandel_config.svh"

module pixel_writer (
   input  logic                      CLOCK2_50,
   input  logic                      reset,
   input  logic                      vga_hs,
   input  logic                      vga_vs,
   input  logic                      empty,
   input  logic [`ITER_W-1:0]        head_count,
   input  logic                      bus_ack,
   output logic                      pop,
   output logic                      bus_write,
   output mandel_pkg::video_write_t  bus_req
);

   localparam int HOLD_MAX = (`VS_HOLD > `HS_HOLD) ? `VS_HOLD : `HS_HOLD;
   localparam int HOLD_W   = $clog2(HOLD_MAX + 1);

   // Index 1 is vertical sync, index 0 horizontal
   localparam logic [1:0][HOLD_W-1:0] HOLD_LEN = {HOLD_W'(`VS_HOLD), HOLD_W'(`HS_HOLD)};

   localparam logic [`COORD_W-1:0] X_LAST = `COORD_W'(`SCREEN_W - 1);
   localparam logic [`COORD_W-1:0] Y_LAST = `COORD_W'(`SCREEN_H - 1);

   mandel_pkg::writer_state_t state;

   logic [1:0]              sync_now;
   logic [1:0]              sync_last;
   logic [1:0]              sync_rise;
   logic [1:0]              sync_hold;
   logic [1:0][HOLD_W-1:0]  hold_left;
   logic                    window_open;

   logic [`COORD_W-1:0] x;
   logic [`COORD_W-1:0] y;
   logic [31:0]         pixel_addr;
   logic [7:0]          colour;
   logic                launch;

   ////////////////////////////////////////////////////////////////////////////
   // Blanking window from the VGA syncs
   ////////////////////////////////////////////////////////////////////////////

   assign sync_now  = {vga_vs, vga_hs};
   assign sync_rise = sync_now & ~sync_last;

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         sync_hold[i] = (hold_left[i] != '0);
      end
   end

   // Open while a sync is low, and for a while after it rises
   assign window_open = |(~sync_now | sync_rise | sync_hold);

   always_ff @(posedge CLOCK2_50) begin
      if (reset) begin
         // Start as if both syncs were high, no edge until one is seen low
         sync_last <= 2'b11;
         hold_left <= '0;
      end else begin
         sync_last <= sync_now;
         for (int i = 0; i < 2; i++) begin
            if (sync_rise[i]) begin
               hold_left[i] <= HOLD_LEN[i] - 1'b1;
            end else if (hold_left[i] != '0) begin
               hold_left[i] <= hold_left[i] - 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Colour map and address
   ////////////////////////////////////////////////////////////////////////////

   // White, red, green, black
   always_comb begin
      case (head_count[1:0])
         2'd3:    colour = 8'hff;
         2'd2:    colour = 8'he0;
         2'd1:    colour = 8'h1c;
         default: colour = 8'h00;
      endcase
   end

   assign pixel_addr = `VIDEO_BASE + 32'(x) + (32'(y) << `ROW_SHIFT);

   ////////////////////////////////////////////////////////////////////////////
   // Bus write FSM
   ////////////////////////////////////////////////////////////////////////////

   assign launch = (state == mandel_pkg::WR_IDLE) && !empty && window_open;
   assign pop    = launch;

   always_ff @(posedge CLOCK2_50) begin
      if (reset) begin
         state     <= mandel_pkg::WR_IDLE;
         bus_write <= 1'b0;
         x         <= '0;
         y         <= '0;
      end else begin
         case (state)
            mandel_pkg::WR_IDLE: begin
               if (launch) begin
                  state     <= mandel_pkg::WR_WAIT_ACK;
                  bus_write <= 1'b1;
                  // Next pixel in raster order
                  if (x == X_LAST) begin
                     x <= '0;
                     y <= (y == Y_LAST) ? '0 : y + 1'b1;
                  end else begin
                     x <= x + 1'b1;
                  end
               end
            end
            mandel_pkg::WR_WAIT_ACK: begin
               if (bus_ack) begin
                  state     <= mandel_pkg::WR_IDLE;
                  bus_write <= 1'b0;
               end
            end
            default: begin
               state     <= mandel_pkg::WR_IDLE;
               bus_write <= 1'b0;
            end
         endcase
      end
   end

   always_ff @(posedge CLOCK2_50) begin
      if (launch) begin
         bus_req <= '{addr: pixel_addr, data: colour};
      end
   end

   // Request holds until the bus acknowledges it
   a_req_held: assert property (
      @(posedge CLOCK2_50) disable iff (reset)
      (bus_write && !bus_ack) |=> (bus_write && $stable(bus_req))
   );

endmodule

/* source/mandel_frame_top.sv */
`timescale 1ns/100ps
`include "mandel_config.svh"

module mandel_frame_top (
   input  logic                      CLOCK2_50,
   input  logic                      reset,
   input  logic                      vga_hs,
   input  logic                      vga_vs,
   input  logic                      bus_ack,
   output logic                      bus_write,
   output mandel_pkg::video_write_t  bus_req
);

   // Iterator to FIFO
   logic               push;
   logic [`ITER_W-1:0] push_count;
   logic               full;

   // FIFO to writer
   logic [`ITER_W-1:0] head_count;
   logic               empty;
   logic               pop;

   mandel_iterator iterator0 (
      .CLOCK2_50  (CLOCK2_50),
      .reset      (reset),
      .full       (full),
      .push       (push),
      .count      (push_count)
   );

   iteration_fifo fifo0 (
      .CLOCK2_50  (CLOCK2_50),
      .reset      (reset),
      .push       (push),
      .push_count (push_count),
      .pop        (pop),
      .head_count (head_count),
      .empty      (empty),
      .full       (full)
   );

   pixel_writer writer0 (
      .CLOCK2_50  (CLOCK2_50),
      .reset      (reset),
      .vga_hs     (vga_hs),
      .vga_vs     (vga_vs),
      .empty      (empty),
      .head_count (head_count),
      .bus_ack    (bus_ack),
      .pop        (pop),
      .bus_write  (bus_write),
      .bus_req    (bus_req)
   );

endmodule

/* bench/mandel_frame_tb.sv */
`timescale 1ns/100ps
`include "mandel_config.svh"

module mandel_frame_tb;

   localparam int TOTAL_WRITES = 2 * `SCREEN_W * `SCREEN_H;
   localparam int CYCLE_LIMIT  = TOTAL_WRITES * (`ITER_MAX + 10);

   logic                     CLOCK2_50;
   logic                     reset;
   logic                     vga_hs;
   logic                     vga_vs;
   logic                     bus_ack;
   logic                     bus_write;
   mandel_pkg::video_write_t bus_req;

   // Sync and acknowledge generator
   int hs_left;
   int vs_left;
   int ack_left;
   bit ack_armed;

   // Checker, window model and raster position of the next write
   int errors;
   int writes;
   int cycles;
   int reset_cycles;
   int max_hits;
   int iter_count;
   int px;
   int py;
   int hs_hold;
   int vs_hold;
   bit prev_write;
   bit prev_done;
   bit win_prev;
   bit win_now;
   bit hs_last;
   bit vs_last;
   bit after_reset;
   bit seen_full;
   mandel_pkg::video_write_t held_req;
   mandel_pkg::video_write_t expect_req;

   mandel_frame_top dut0 (
      .CLOCK2_50 (CLOCK2_50),
      .reset     (reset),
      .vga_hs    (vga_hs),
      .vga_vs    (vga_vs),
      .bus_ack   (bus_ack),
      .bus_write (bus_write),
      .bus_req   (bus_req)
   );

   always #50 CLOCK2_50 = ~CLOCK2_50;

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic signed [`FIX_W-1:0] fix_product(
      input logic signed [`FIX_W-1:0] a,
      input logic signed [`FIX_W-1:0] b
   );
      longint p;
      p = longint'(a) * longint'(b);
      return `FIX_W'(p >>> `FIX_FRAC);
   endfunction

   // Escape-time count of one pixel with z starting at 0
   function automatic int ref_iterations(input int x, input int y);
      mandel_pkg::plane_point_t c;
      logic signed [`FIX_W-1:0] zr;
      logic signed [`FIX_W-1:0] zi;
      logic signed [`FIX_W-1:0] zr2;
      logic signed [`FIX_W-1:0] zi2;
      logic signed [`FIX_W-1:0] zr_new;
      logic signed [`FIX_W-1:0] zi_new;
      c.re = `FIX_W'(`RE_MIN + x * `RE_STEP);
      c.im = `FIX_W'(`IM_MAX - y * `IM_STEP);
      zr   = '0;
      zi   = '0;
      zr2  = '0;
      zi2  = '0;
      for (int n = 1; n <= `ITER_MAX; n++) begin
         zr_new = zr2 - zi2 + c.re;
         zi_new = `FIX_W'(2 * int'(fix_product(zr, zi))) + c.im;
         zr2    = fix_product(zr_new, zr_new);
         zi2    = fix_product(zi_new, zi_new);
         if (int'(zr2) + int'(zi2) > `ESCAPE_LIMIT) begin
            return n;
         end
         zr = zr_new;
         zi = zi_new;
      end
      return `ITER_MAX;
   endfunction

   // Byte address in the frame and colour from the two low count bits
   function automatic mandel_pkg::video_write_t expected_write(
      input int x,
      input int y,
      input int iterations
   );
      mandel_pkg::video_write_t w;
      w.addr = `VIDEO_BASE + 32'(x) + 32'(y * (1 << `ROW_SHIFT));
      case (iterations % 4)
         3:       w.data = 8'hff;
         2:       w.data = 8'he0;
         1:       w.data = 8'h1c;
         default: w.data = 8'h00;
      endcase
      return w;
   endfunction

   task automatic finish_run();
      $display("writes %0d, pixels at limit %0d, errors %0d", writes, max_hits, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(32'hfca9));
      CLOCK2_50 = 1'b0;
      reset     = 1'b1;
      vga_hs    = 1'b1;
      vga_vs    = 1'b1;
      bus_ack   = 1'b0;
      repeat (16) @(posedge CLOCK2_50);
      reset <= 1'b0;
   end

   // Short low sync pulses between active stretches
   always @(posedge CLOCK2_50) begin
      if (reset) begin
         vga_hs    <= 1'b1;
         vga_vs    <= 1'b1;
         bus_ack   <= 1'b0;
         hs_left   = 5;
         vs_left   = 200;
         ack_armed = 1'b0;
      end else begin
         if (hs_left == 0) begin
            vga_hs  <= !vga_hs;
            hs_left = vga_hs ? $urandom_range(2, 0) : $urandom_range(30, 4);
         end else begin
            hs_left--;
         end
         if (vs_left == 0) begin
            vga_vs  <= !vga_vs;
            vs_left = vga_vs ? $urandom_range(6, 2) : $urandom_range(400, 150);
         end else begin
            vs_left--;
         end
         // Acknowledge 0 to 5 cycles after the write is seen
         if (bus_ack) begin
            bus_ack <= 1'b0;
         end else if (bus_write) begin
            if (!ack_armed) begin
               ack_armed = 1'b1;
               ack_left  = $urandom_range(5, 0);
            end
            if (ack_left == 0) begin
               bus_ack   <= 1'b1;
               ack_armed = 1'b0;
            end else begin
               ack_left--;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checker
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge CLOCK2_50) begin
      if (reset) begin
         // Outputs are defined from the first edge in reset on
         if (reset_cycles > 0) begin
            assert (!bus_write) else begin
               errors++;
               $display("Fail %0t bus_write got %b expected 0", $time, bus_write);
            end
         end
         reset_cycles++;
         px          = 0;
         py          = 0;
         hs_last     = 1'b1;
         vs_last     = 1'b1;
         hs_hold     = 0;
         vs_hold     = 0;
         prev_write  = 1'b0;
         prev_done   = 1'b0;
         win_prev    = 1'b0;
         after_reset = 1'b1;
      end else begin
         if (after_reset) begin
            assert (!bus_write) else begin
               errors++;
               $display("Fail %0t bus_write got %b expected 0", $time, bus_write);
            end
            after_reset = 1'b0;
         end
         // Window as the writer sees it on this edge
         if (vga_hs && !hs_last) begin
            hs_hold = `HS_HOLD;
         end
         if (vga_vs && !vs_last) begin
            vs_hold = `VS_HOLD;
         end
         win_now = !vga_hs || !vga_vs || (hs_hold > 0) || (vs_hold > 0);
         hs_hold = (hs_hold > 0) ? hs_hold - 1 : 0;
         vs_hold = (vs_hold > 0) ? vs_hold - 1 : 0;
         hs_last = vga_hs;
         vs_last = vga_vs;

         if (bus_write && !prev_write) begin
            assert (win_prev) else begin
               errors++;
               $display("Write to %h started at %0t with the window closed",
                        bus_req.addr, $time);
            end
         end
         if (prev_done) begin
            assert (!bus_write) else begin
               errors++;
               $display("Fail %0t bus_write got %b expected 0", $time, bus_write);
            end
         end else if (prev_write) begin
            assert (bus_write) else begin
               errors++;
               $display("Fail %0t bus_write got %b expected 1", $time, bus_write);
            end
            assert (bus_req == held_req) else begin
               errors++;
               $display("Fail %0t bus_req got %h expected %h", $time, bus_req, held_req);
            end
         end

         // Completed write against the next pixel in raster order
         if (bus_write && bus_ack) begin
            iter_count = ref_iterations(px, py);
            expect_req = expected_write(px, py, iter_count);
            if (iter_count == `ITER_MAX) begin
               max_hits++;
            end
            assert (bus_req.addr == expect_req.addr) else begin
               errors++;
               $display("Fail %0t bus_req.addr got %h expected %h",
                        $time, bus_req.addr, expect_req.addr);
            end
            assert (bus_req.data == expect_req.data) else begin
               errors++;
               $display("Fail %0t bus_req.data got %h expected %h",
                        $time, bus_req.data, expect_req.data);
            end
            writes++;
            px = (px == `SCREEN_W - 1) ? 0 : px + 1;
            if (px == 0) begin
               py = (py == `SCREEN_H - 1) ? 0 : py + 1;
            end
         end

         if (dut0.full) begin
            seen_full = 1'b1;
         end
         prev_write = bus_write;
         prev_done  = bus_write && bus_ack;
         held_req   = bus_req;
         win_prev   = win_now;

         if (writes == TOTAL_WRITES) begin
            assert (seen_full) else begin
               errors++;
               $display("FIFO never filled, so the iterator never stalled");
            end
            assert (max_hits > 0) else begin
               errors++;
               $display("No pixel reached the iteration limit");
            end
            finish_run();
         end
      end
   end

   always @(posedge CLOCK2_50) begin
      cycles++;
      if (cycles == CYCLE_LIMIT) begin
         errors++;
         $display("Timeout after %0d cycles with %0d of %0d writes done",
                  cycles, writes, TOTAL_WRITES);
         finish_run();
      end
   end

endmodule

/* mandel_frame_top.f */
+incdir+include
source/mandel_pkg.sv
source/mandel_iterator.sv
source/iteration_fifo.sv
source/pixel_writer.sv
source/mandel_frame_top.sv
bench/mandel_frame_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run the simulation into a log, then scan the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module mandel_frame_tb \
   -f mandel_frame_top.f -o mandel_frame_sim \
   && ./obj_dir/mandel_frame_sim > "$log" 2>&1 \
   || { echo "Build or simulation error, see $log"; exit 1; }

grep -q "tests failed" "$log" \
   && { echo "Simulation failed, see $log"; exit 1; } \
   || echo "Simulation passed"
